//--- branchUnit_params.svh
`ifndef BRANCH_UNIT_PARAMS_SVH
`define BRANCH_UNIT_PARAMS_SVH

// station geometry and datapath widths
`define RS_SIZE 4
`define DATA_W 32
`define ADDR_W 32
`define TAG_W 4

// dispatch stall after a redirect, in cycles
`define REFILL_CYCLES 3

`endif

//--- cdbPkg.sv
`include "branchUnit_params.svh"

package cdbPkg;

    // producer tag, zero means the operand is already present
    typedef logic [`TAG_W-1:0] tag_t;

    localparam tag_t NO_TAG = '0;

    // one result broadcast on the common data bus
    typedef struct packed {
        logic              valid;
        tag_t              tag;
        logic [`DATA_W-1:0] data;
    } cdbMsg_t;

endpackage

//--- branchPkg.sv
`include "branchUnit_params.svh"

package branchPkg;

    // NOP doubles as the empty-slot marker
    typedef enum logic [3:0] {
        NOP,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        JAL,
        JALR
    } branchOp_e;

    // instruction as written by the dispatcher
    typedef struct packed {
        branchOp_e          op;
        logic [`DATA_W-1:0] operandA;
        logic [`DATA_W-1:0] operandB;
        cdbPkg::tag_t       tagA;
        cdbPkg::tag_t       tagB;
        logic [`DATA_W-1:0] imm;
        logic [`ADDR_W-1:0] pc;
        logic               predTaken;
        cdbPkg::tag_t       destTag;
    } dispatchEntry_t;

    // ready instruction handed to the execute stage
    typedef struct packed {
        logic               valid;
        branchOp_e          op;
        logic [`DATA_W-1:0] operandA;
        logic [`DATA_W-1:0] operandB;
        logic [`DATA_W-1:0] imm;
        logic [`ADDR_W-1:0] pc;
        logic               predTaken;
        cdbPkg::tag_t       destTag;
    } issueBundle_t;

    // resolved outcome of one branch
    typedef struct packed {
        logic               valid;
        logic               taken;
        logic [`ADDR_W-1:0] target;
        logic               mispredict;
        cdbPkg::tag_t       destTag;
    } resolve_t;

    typedef enum logic [1:0] {
        RUN,
        REDIRECT,
        REFILL
    } ctrlState_e;

endpackage

//--- refillTimer.sv
`timescale 1ns/1ps
`include "branchUnit_params.svh"

module refillTimer (
    input  logic clk,
    input  logic rst,
    input  logic timerStart,
    output logic timerDone
);
    localparam int CNT_W = $clog2(`REFILL_CYCLES + 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (timerStart) begin
            count <= CNT_W'(`REFILL_CYCLES);
        end else if (count != '0) begin
            count <= count - CNT_W'(1);
        end
    end

    // high in the last refill cycle, the count hits zero on the next edge
    assign timerDone = (count == CNT_W'(1));

endmodule

//--- branchRs.sv
`timescale 1ns/1ps
`include "branchUnit_params.svh"

module branchRs (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    dispatchValid,
    input  branchPkg::dispatchEntry_t dispatchEntry,
    input  cdbPkg::cdbMsg_t         cdbIn,
    input  logic                    issueEnable,
    input  logic                    flush,
    output branchPkg::issueBundle_t issueOut,
    output logic                    rsFull
);
    import cdbPkg::*;
    import branchPkg::*;

    localparam int IDX_W = $clog2(`RS_SIZE);

    dispatchEntry_t slots [`RS_SIZE];
    dispatchEntry_t incoming;

    logic [`RS_SIZE-1:0] slotReady;
    logic [IDX_W-1:0]    freeIdx;
    logic [IDX_W-1:0]    issueIdx;
    logic                freeFound;
    logic                readyFound;
    logic                cdbHit;
    logic                dispatchFire;
    logic                issueFire;

    // tag zero never names a producer
    assign cdbHit = cdbIn.valid && (cdbIn.tag != NO_TAG);

    // a slot is ready once both source tags are cleared
    always_comb begin
        for (int i = 0; i < `RS_SIZE; i++) begin
            slotReady[i] = (slots[i].op != NOP) &&
                           (slots[i].tagA == NO_TAG) &&
                           (slots[i].tagB == NO_TAG);
        end
    end

    // scan downwards so the lowest index wins
    always_comb begin
        freeFound  = 1'b0;
        freeIdx    = '0;
        readyFound = 1'b0;
        issueIdx   = '0;
        for (int i = `RS_SIZE - 1; i >= 0; i--) begin
            if (slots[i].op == NOP) begin
                freeFound = 1'b1;
                freeIdx   = IDX_W'(i);
            end
            if (slotReady[i]) begin
                readyFound = 1'b1;
                issueIdx   = IDX_W'(i);
            end
        end
    end

    assign rsFull       = !freeFound;
    assign dispatchFire = dispatchValid && freeFound;
    assign issueFire    = issueEnable && readyFound;

    // broadcast in the dispatch cycle is captured on the way in
    always_comb begin
        incoming = dispatchEntry;
        if (cdbHit && (dispatchEntry.tagA == cdbIn.tag)) begin
            incoming.operandA = cdbIn.data;
            incoming.tagA     = NO_TAG;
        end
        if (cdbHit && (dispatchEntry.tagB == cdbIn.tag)) begin
            incoming.operandB = cdbIn.data;
            incoming.tagB     = NO_TAG;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int i = 0; i < `RS_SIZE; i++) begin
                slots[i].op <= NOP;
            end
            issueOut.valid <= 1'b0;
        end else begin
            // wakeup of waiting slots
            if (cdbHit) begin
                for (int i = 0; i < `RS_SIZE; i++) begin
                    if (slots[i].op != NOP && slots[i].tagA == cdbIn.tag) begin
                        slots[i].operandA <= cdbIn.data;
                        slots[i].tagA     <= NO_TAG;
                    end
                    if (slots[i].op != NOP && slots[i].tagB == cdbIn.tag) begin
                        slots[i].operandB <= cdbIn.data;
                        slots[i].tagB     <= NO_TAG;
                    end
                end
            end

            issueOut.valid <= issueFire;
            if (issueFire) begin
                issueOut.op        <= slots[issueIdx].op;
                issueOut.operandA  <= slots[issueIdx].operandA;
                issueOut.operandB  <= slots[issueIdx].operandB;
                issueOut.imm       <= slots[issueIdx].imm;
                issueOut.pc        <= slots[issueIdx].pc;
                issueOut.predTaken <= slots[issueIdx].predTaken;
                issueOut.destTag   <= slots[issueIdx].destTag;
                slots[issueIdx].op <= NOP;
            end

            // free slot is never the issuing one
            if (dispatchFire) begin
                slots[freeIdx] <= incoming;
            end
        end
    end

endmodule

//--- branchExec.sv
`timescale 1ns/1ps
`include "branchUnit_params.svh"

module branchExec (
    input  logic                    clk,
    input  logic                    rst,
    input  branchPkg::issueBundle_t issueIn,
    input  logic                    kill,
    output branchPkg::resolve_t     resolveOut,
    output cdbPkg::cdbMsg_t         linkOut,
    output logic                    mispredict,
    output logic [`ADDR_W-1:0]      redirectTarget
);
    import branchPkg::*;

    logic               taken;
    logic               isJump;
    logic               live;
    logic [`ADDR_W-1:0] pcPlus4;
    logic [`ADDR_W-1:0] jalrSum;
    logic [`ADDR_W-1:0] takenTarget;
    logic [`ADDR_W-1:0] target;

    always_comb begin
        case (issueIn.op)
            BEQ:       taken = issueIn.operandA == issueIn.operandB;
            BNE:       taken = issueIn.operandA != issueIn.operandB;
            BLT:       taken = $signed(issueIn.operandA) < $signed(issueIn.operandB);
            BGE:       taken = $signed(issueIn.operandA) >= $signed(issueIn.operandB);
            BLTU:      taken = issueIn.operandA < issueIn.operandB;
            BGEU:      taken = issueIn.operandA >= issueIn.operandB;
            JAL, JALR: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    assign isJump  = (issueIn.op == JAL) || (issueIn.op == JALR);
    assign pcPlus4 = issueIn.pc + `ADDR_W'(4);
    assign jalrSum = issueIn.operandA[`ADDR_W-1:0] + issueIn.imm[`ADDR_W-1:0];

    // jalr drops bit 0 of the sum
    assign takenTarget = (issueIn.op == JALR) ? {jalrSum[`ADDR_W-1:1], 1'b0}
                                              : issueIn.pc + issueIn.imm[`ADDR_W-1:0];
    assign target = taken ? takenTarget : pcPlus4;

    // killed entries are younger than a mispredicted branch
    assign live = issueIn.valid && !kill;

    // raw pulse, one cycle ahead of resolveOut
    assign mispredict     = live && (taken != issueIn.predTaken);
    assign redirectTarget = target;

    always_ff @(posedge clk) begin
        resolveOut.taken      <= taken;
        resolveOut.target     <= target;
        resolveOut.mispredict <= taken != issueIn.predTaken;
        resolveOut.destTag    <= issueIn.destTag;
        linkOut.tag           <= issueIn.destTag;
        linkOut.data          <= `DATA_W'(pcPlus4);
        if (rst) begin
            resolveOut.valid <= 1'b0;
            linkOut.valid    <= 1'b0;
        end else begin
            resolveOut.valid <= live;
            linkOut.valid    <= live && isJump;
        end
    end

endmodule

//--- branchCtrl.sv
`timescale 1ns/1ps
`include "branchUnit_params.svh"

module branchCtrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               mispredict,
    input  logic [`ADDR_W-1:0] redirectTarget,
    input  logic               timerDone,
    output logic               redirectValid,
    output logic [`ADDR_W-1:0] redirectPc,
    output logic               flush,
    output logic               kill,
    output logic               issueEnable,
    output logic               timerStart,
    output logic               stall
);
    import branchPkg::*;

    ctrlState_e state;
    ctrlState_e nextState;

    always_comb begin
        nextState = state;
        case (state)
            RUN: begin
                if (mispredict) begin
                    nextState = REDIRECT;
                end
            end
            // single cycle, lines up with the mispredict on resolveOut
            REDIRECT: nextState = REFILL;
            REFILL: begin
                if (timerDone) begin
                    nextState = RUN;
                end
            end
            default: nextState = RUN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RUN;
        end else begin
            state <= nextState;
        end
    end

    // target latched as the branch moves into the execute register
    always_ff @(posedge clk) begin
        if (state == RUN && mispredict) begin
            redirectPc <= redirectTarget;
        end
    end

    assign redirectValid = (state == REDIRECT);
    assign flush         = (state == REDIRECT);
    assign kill          = (state == REDIRECT);
    assign timerStart    = (state == REDIRECT);

    // everything in flight is wrong-path during a redirect
    assign issueEnable = (state == RUN);
    assign stall       = (state != RUN);

endmodule

//--- branchUnit.sv
`timescale 1ns/1ps
`include "branchUnit_params.svh"

module branchUnit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      dispatchValid,
    input  branchPkg::dispatchEntry_t dispatchEntry,
    output logic                      rsFull,
    input  cdbPkg::cdbMsg_t           cdbIn,
    output branchPkg::resolve_t       resolveOut,
    output cdbPkg::cdbMsg_t           linkOut,
    output logic                      redirectValid,
    output logic [`ADDR_W-1:0]        redirectPc,
    output logic                      stall
);
    import branchPkg::*;

    issueBundle_t       issue;
    logic               issueEnable;
    logic               flush;
    logic               kill;
    logic               mispredict;
    logic [`ADDR_W-1:0] redirectTarget;
    logic               timerStart;
    logic               timerDone;

    // dispatch is held off while the refill stall is up
    branchRs branchRs_i (
        .clk           (clk),
        .rst           (rst),
        .dispatchValid (dispatchValid && !stall),
        .dispatchEntry (dispatchEntry),
        .cdbIn         (cdbIn),
        .issueEnable   (issueEnable),
        .flush         (flush),
        .issueOut      (issue),
        .rsFull        (rsFull)
    );

    branchExec branchExec_i (
        .clk            (clk),
        .rst            (rst),
        .issueIn        (issue),
        .kill           (kill),
        .resolveOut     (resolveOut),
        .linkOut        (linkOut),
        .mispredict     (mispredict),
        .redirectTarget (redirectTarget)
    );

    branchCtrl branchCtrl_i (
        .clk            (clk),
        .rst            (rst),
        .mispredict     (mispredict),
        .redirectTarget (redirectTarget),
        .timerDone      (timerDone),
        .redirectValid  (redirectValid),
        .redirectPc     (redirectPc),
        .flush          (flush),
        .kill           (kill),
        .issueEnable    (issueEnable),
        .timerStart     (timerStart),
        .stall          (stall)
    );

    refillTimer refillTimer_i (
        .clk        (clk),
        .rst        (rst),
        .timerStart (timerStart),
        .timerDone  (timerDone)
    );

endmodule

//--- branchUnit_props.sv
`timescale 1ns/1ps
`include "branchUnit_params.svh"

module branchUnit_props (
    input logic                clk,
    input logic                rst,
    input logic                stall,
    input logic                redirectValid,
    input logic                issueValid,
    input branchPkg::resolve_t resolveOut,
    input cdbPkg::cdbMsg_t     linkOut
);

    // redirect only in the cycle of a mispredicted resolve
    redirectOnMispredict: assert property (@(posedge clk) disable iff (rst)
        redirectValid |-> resolveOut.valid && resolveOut.mispredict)
        else $error("redirect without a mispredicted resolve");

    // an entry taken in during the stall would issue right after it ends
    noDispatchInStall: assert property (@(posedge clk) disable iff (rst)
        $fell(stall) |=> !issueValid)
        else $error("entry issued right after the refill stall");

    // link results travel with their resolve
    linkWithResolve: assert property (@(posedge clk) disable iff (rst)
        linkOut.valid |-> resolveOut.valid)
        else $error("link broadcast without a resolve");

endmodule

//--- branchUnitTb.sv
`timescale 1ns/1ps
`include "branchUnit_params.svh"

module branchUnitTb;
    import cdbPkg::*;
    import branchPkg::*;

    logic               clk = 1'b0;
    logic               rst;
    logic               dispatchValid;
    dispatchEntry_t     dispatchEntry;
    logic               rsFull;
    cdbMsg_t            cdbIn;
    resolve_t           resolveOut;
    cdbMsg_t            linkOut;
    logic               redirectValid;
    logic [`ADDR_W-1:0] redirectPc;
    logic               stall;

    // reference model, pending entries indexed by destTag
    dispatchEntry_t pending [16];
    logic [15:0]    pendValid = '0;
    logic [31:0]    lfsrState = 32'hce60;
    logic [31:0]    dataA;
    logic [31:0]    dataB;
    dispatchEntry_t e;
    branchOp_e      linkOps [3] = '{JAL, BEQ, JALR};
    string          testName = "reset";
    int             tagCounter = 0;
    int             errorCount = 0;
    int             checkCount = 0;
    int             testErrors = 0;
    int             linkCount = 0;
    int             waitCycles;

    branchUnit branchUnit_i (.*);

    bind branchUnit branchUnit_props branchUnit_props_i (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .redirectValid (redirectValid),
        .issueValid    (issue.valid),
        .resolveOut    (resolveOut),
        .linkOut       (linkOut)
    );

    always #5 clk = ~clk;

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = {lfsrState[30:0],
                         lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
            r = {r[30:0], lfsrState[0]};
        end
        return r;
    endfunction

    function automatic logic modelTaken(input dispatchEntry_t d);
        case (d.op)
            BEQ:       return d.operandA == d.operandB;
            BNE:       return d.operandA != d.operandB;
            BLT:       return $signed(d.operandA) < $signed(d.operandB);
            BGE:       return $signed(d.operandA) >= $signed(d.operandB);
            BLTU:      return d.operandA < d.operandB;
            BGEU:      return d.operandA >= d.operandB;
            JAL, JALR: return 1'b1;
            default:   return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] modelTarget(input dispatchEntry_t d);
        if (!modelTaken(d)) begin
            return d.pc + 32'd4;
        end
        if (d.op == JALR) begin
            return (d.operandA + d.imm) & ~32'h1;
        end
        return d.pc + d.imm;
    endfunction

    // operands present, prediction matches the model
    function automatic dispatchEntry_t randomEntry();
        dispatchEntry_t r;
        logic [31:0]    off;
        r = '0;
        r.op = branchOp_e'(randBits(3) + 1);
        r.operandA = randBits(32);
        r.operandB = (randBits(2) == 0) ? r.operandA : randBits(32);
        off = randBits(12);
        r.imm = {{20{off[11]}}, off[11:1], 1'b0};
        r.pc = {randBits(30), 2'b00};
        r.predTaken = modelTaken(r);
        r.destTag = tag_t'(tagCounter % 15 + 1);
        tagCounter++;
        return r;
    endfunction

    // predicts with the data still to come, then hides it behind tags
    function automatic dispatchEntry_t waitOn(input dispatchEntry_t d, input tag_t tagA,
                                              input logic [31:0] valueA, input tag_t tagB,
                                              input logic [31:0] valueB);
        if (tagA != NO_TAG) begin
            d.operandA = valueA;
        end
        if (tagB != NO_TAG) begin
            d.operandB = valueB;
        end
        d.predTaken = modelTaken(d);
        if (tagA != NO_TAG) begin
            d.operandA = ~valueA;
            d.tagA = tagA;
        end
        if (tagB != NO_TAG) begin
            d.operandB = ~valueB;
            d.tagB = tagB;
        end
        return d;
    endfunction

    function automatic dispatchEntry_t applyCdb(input dispatchEntry_t d);
        if (cdbIn.valid && cdbIn.tag != NO_TAG && d.tagA == cdbIn.tag) begin
            d.operandA = cdbIn.data;
            d.tagA = NO_TAG;
        end
        if (cdbIn.valid && cdbIn.tag != NO_TAG && d.tagB == cdbIn.tag) begin
            d.operandB = cdbIn.data;
            d.tagB = NO_TAG;
        end
        return d;
    endfunction

    task automatic checkValue(input string what, input logic [63:0] expected,
                              input logic [63:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("mismatch in %s, %s: expected %0h, actual %0h",
                     testName, what, expected, actual);
        end
    endtask

    task automatic reportFailure(input string what);
        errorCount++;
        $display("error in %s: %s", testName, what);
    endtask

    task automatic checkResolve();
        dispatchEntry_t r;
        logic           taken;
        tag_t           t;
        t = resolveOut.destTag;
        if (!resolveOut.valid) begin
            checkValue("redirectValid", 0, redirectValid);
            checkValue("linkOut.valid", 0, linkOut.valid);
        end else if (!pendValid[t]) begin
            reportFailure($sformatf("resolve for tag %0d with no pending branch", t));
        end else begin
            r = pending[t];
            taken = modelTaken(r);
            if (r.tagA != NO_TAG || r.tagB != NO_TAG) begin
                reportFailure("branch resolved before its operands arrived");
            end
            checkValue("taken", taken, resolveOut.taken);
            checkValue("target", modelTarget(r), resolveOut.target);
            checkValue("mispredict", taken != r.predTaken, resolveOut.mispredict);
            checkValue("redirectValid", taken != r.predTaken, redirectValid);
            checkValue("linkOut.valid", r.op == JAL || r.op == JALR, linkOut.valid);
            pendValid[t] = 1'b0;
            if (linkOut.valid) begin
                linkCount++;
                checkValue("linkOut.tag", r.destTag, linkOut.tag);
                checkValue("linkOut.data", r.pc + 32'd4, linkOut.data);
            end
            // everything still pending is younger and gets flushed
            if (taken != r.predTaken) begin
                checkValue("redirectPc", modelTarget(r), redirectPc);
                pendValid = '0;
            end
        end
    endtask

    // inputs are stable at the falling edge, model what the next edge takes
    always @(negedge clk) begin
        if (!rst) begin
            checkResolve();
            for (int t = 1; t < 16; t++) begin
                if (pendValid[t]) begin
                    pending[t] = applyCdb(pending[t]);
                end
            end
            if (dispatchValid && !rsFull && !stall) begin
                pending[dispatchEntry.destTag] = applyCdb(dispatchEntry);
                pendValid[dispatchEntry.destTag] = 1'b1;
            end
        end
    end

    task automatic driveDispatch(input dispatchEntry_t d);
        int cycles = 0;
        dispatchValid = 1'b1;
        dispatchEntry = d;
        while ((rsFull || stall) && cycles < 50) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (cycles == 50) begin
            reportFailure("dispatch was never accepted");
        end
        @(posedge clk);
        #1;
        dispatchValid = 1'b0;
        cdbIn.valid = 1'b0;
    endtask

    task automatic broadcast(input tag_t tag, input logic [31:0] data);
        cdbIn = {1'b1, tag, data};
        @(posedge clk);
        #1;
        cdbIn.valid = 1'b0;
    endtask

    task automatic waitDrained();
        int cycles = 0;
        while ((pendValid != '0 || stall) && cycles < 100) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (pendValid != '0 || stall) begin
            reportFailure("pending branches never resolved");
            pendValid = '0;
        end
    endtask

    task automatic finishTest();
        $display("test %s: %0d errors", testName, errorCount - testErrors);
        testErrors = errorCount;
    endtask

    initial begin
        rst = 1'b1;
        dispatchValid = 1'b0;
        dispatchEntry = '0;
        cdbIn = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        checkValue("resolveOut.valid", 0, resolveOut.valid);
        checkValue("linkOut.valid", 0, linkOut.valid);
        checkValue("redirectValid", 0, redirectValid);
        checkValue("stall", 0, stall);
        checkValue("rsFull", 0, rsFull);
        finishTest();

        testName = "condition";
        repeat (12) begin
            driveDispatch(randomEntry());
        end
        waitDrained();
        finishTest();

        testName = "wakeup";
        dataA = randBits(32);
        dataB = randBits(32);
        driveDispatch(waitOn(randomEntry(), 3, dataA, 0, 0));
        driveDispatch(waitOn(randomEntry(), 3, dataA, 5, dataB));
        // nothing may resolve while the tags are outstanding
        repeat (4) @(posedge clk);
        #1;
        broadcast(3, dataA);
        broadcast(5, dataB);
        cdbIn = {1'b1, tag_t'(6), dataB};
        driveDispatch(waitOn(randomEntry(), 0, 0, 6, dataB));
        waitDrained();
        finishTest();

        testName = "full";
        dataA = randBits(32);
        repeat (`RS_SIZE) begin
            driveDispatch(waitOn(randomEntry(), 7, dataA, 0, 0));
        end
        e = randomEntry();
        dispatchValid = 1'b1;
        dispatchEntry = e;
        repeat (3) begin
            @(posedge clk);
            #1;
            checkValue("rsFull", 1, rsFull);
        end
        broadcast(7, dataA);
        driveDispatch(e);
        waitDrained();
        finishTest();

        testName = "mispredict";
        dataA = randBits(32);
        repeat (2) begin
            driveDispatch(waitOn(randomEntry(), 9, dataA, 0, 0));
        end
        e = randomEntry();
        e.predTaken = !e.predTaken;
        driveDispatch(e);
        driveDispatch(randomEntry());
        waitCycles = 0;
        while (!redirectValid && waitCycles < 20) begin
            @(posedge clk);
            #1;
            waitCycles++;
        end
        if (!redirectValid) begin
            reportFailure("no redirect after a mispredicted branch");
        end
        // request held through the whole stall
        e = randomEntry();
        dispatchEntry = e;
        dispatchValid = 1'b1;
        waitCycles = 0;
        while (stall && waitCycles < 20) begin
            @(posedge clk);
            #1;
            waitCycles++;
        end
        checkValue("stall cycles", `REFILL_CYCLES + 1, waitCycles);
        driveDispatch(e);
        // flushed entries must stay gone even when their tag shows up
        broadcast(9, dataA);
        repeat (3) begin
            driveDispatch(randomEntry());
        end
        waitDrained();
        finishTest();

        testName = "link";
        linkCount = 0;
        foreach (linkOps[i]) begin
            e = randomEntry();
            e.op = linkOps[i];
            e.predTaken = modelTaken(e);
            driveDispatch(e);
        end
        waitDrained();
        checkValue("link count", 2, linkCount);
        finishTest();

        $display("tests 6, checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+.
cdbPkg.sv
branchPkg.sv
refillTimer.sv
branchRs.sv
branchExec.sv
branchCtrl.sv
branchUnit.sv
branchUnit_props.sv
branchUnitTb.sv

//--- Bender.yml
package:
  name: branchUnit

sources:
  - include_dirs:
      - .
    files:
      - cdbPkg.sv
      - branchPkg.sv
      - refillTimer.sv
      - branchRs.sv
      - branchExec.sv
      - branchCtrl.sv
      - branchUnit.sv
  - target: test
    include_dirs:
      - .
    files:
      - branchUnit_props.sv
      - branchUnitTb.sv
